// ==== design/corr_pkg.sv ====
package corr_pkg;

   // ----------------------------------------
   // Array and accumulator sizes
   // ----------------------------------------
   // Antennas per sample strobe
   localparam int ANT_COUNT = 24;

   // Pairs visited per pass, one per clock
   localparam int PAIR_COUNT = 12;
   localparam int INDEX_BITS = 4;

   // Each half of a visibility, wraps modulo 2^ACCUM_BITS
   localparam int ACCUM_BITS = 12;

   // Sine in upper half, cosine in lower half
   localparam int VIS_BITS = 2 * ACCUM_BITS;

   // Last pair index of a pass
   localparam logic [INDEX_BITS-1:0] LAST_PAIR = INDEX_BITS'(PAIR_COUNT - 1);

   // ----------------------------------------
   // Pair table
   // ----------------------------------------
   // Antenna number width, and one entry is {b, a}
   localparam int ANT_SEL_BITS = 5;
   localparam int PAIR_BITS = 2 * ANT_SEL_BITS;

   // Entry k sits at bits [k*PAIR_BITS +: PAIR_BITS]
   // Disjoint neighbour pairs, entry 11 first
   localparam logic [PAIR_COUNT*PAIR_BITS-1:0] PAIR_TABLE = {
      5'd23, 5'd22,
      5'd21, 5'd20,
      5'd19, 5'd18,
      5'd17, 5'd16,
      5'd15, 5'd14,
      5'd13, 5'd12,
      5'd11, 5'd10,
      5'd09, 5'd08,
      5'd07, 5'd06,
      5'd05, 5'd04,
      5'd03, 5'd02,
      5'd01, 5'd00
   };

   // Sequencer FSM states
   typedef enum logic [0:0] {
      SEQ_IDLE,
      SEQ_RUN
   } seq_state_t;

endpackage

// ==== design/corr_sample_if.sv ====
`timescale 1ns/10ps

// One time-multiplexed slot of the sample stream
interface corr_sample_if;

   // Slot valid, rd names the pair this cycle
   logic                            en;
   // Clear request, steady over a whole pass
   logic                            sw;
   logic [corr_pkg::INDEX_BITS-1:0] rd;

   // Latched antenna words, held for the pass
   logic [corr_pkg::ANT_COUNT-1:0]  re;
   logic [corr_pkg::ANT_COUNT-1:0]  im;

   // Sequencer side
   modport seq (output en, sw, rd, re, im);

   // Correlator side
   modport corr (input en, sw, rd, re, im);

endinterface

// ==== design/corr_sequencer.sv ====
`timescale 1ns/10ps

module corr_sequencer (
   input  logic                           clk_x,
   input  logic                           rst_n,
   input  logic                           stb,
   input  logic                           sw_req,
   input  logic [corr_pkg::ANT_COUNT-1:0] re,
   input  logic [corr_pkg::ANT_COUNT-1:0] im,
   corr_sample_if.seq                     smp
);

   corr_pkg::seq_state_t            state;
   logic [corr_pkg::INDEX_BITS-1:0] cnt;
   logic                            sw_pend;
   logic                            sw_pass;
   logic [corr_pkg::ANT_COUNT-1:0]  re_q;
   logic [corr_pkg::ANT_COUNT-1:0]  im_q;

   // ----------------------------------------
   // Pass control
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         state   <= corr_pkg::SEQ_IDLE;
         cnt     <= '0;
         sw_pend <= 1'b0;
         sw_pass <= 1'b0;
      end else begin
         // Remember a clear until a pass picks it up
         if (sw_req) begin
            sw_pend <= 1'b1;
         end

         case (state)
            corr_pkg::SEQ_IDLE: begin
               if (stb) begin
                  state   <= corr_pkg::SEQ_RUN;
                  cnt     <= '0;
                  // Same-edge request also counts for this pass
                  sw_pass <= sw_pend | sw_req;
                  sw_pend <= 1'b0;
               end
            end
            corr_pkg::SEQ_RUN: begin
               if (cnt == corr_pkg::LAST_PAIR) begin
                  state   <= corr_pkg::SEQ_IDLE;
                  cnt     <= '0;
                  sw_pass <= 1'b0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               state <= corr_pkg::SEQ_IDLE;
            end
         endcase
      end
   end

   // Sample words, held over the pass
   always_ff @(posedge clk_x) begin
      if (stb && state == corr_pkg::SEQ_IDLE) begin
         re_q <= re;
         im_q <= im;
      end
   end

   // ----------------------------------------
   // Slot outputs
   // ----------------------------------------
   assign smp.en = (state == corr_pkg::SEQ_RUN);
   assign smp.sw = sw_pass;
   assign smp.rd = cnt;
   assign smp.re = re_q;
   assign smp.im = im_q;

   // Strobes at least PAIR_COUNT + 1 cycles apart
   a_stb_spacing: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      stb |=> (!stb) [*corr_pkg::PAIR_COUNT]
   ) else $error("stb arrived while a pass was running");

endmodule

// ==== design/corr_cos_sin.sv ====
`timescale 1ns/10ps

module corr_cos_sin (
   input  logic                            clk_x,
   input  logic                            rst_n,
   input  logic                            en,
   input  logic                            ar,
   input  logic                            br,
   input  logic                            bi,
   input  logic [corr_pkg::ACCUM_BITS-1:0] dcos,
   input  logic [corr_pkg::ACCUM_BITS-1:0] dsin,
   output logic                            valid,
   output logic [corr_pkg::ACCUM_BITS-1:0] qcos,
   output logic [corr_pkg::ACCUM_BITS-1:0] qsin
);

   logic cos_hit;
   logic sin_hit;

   // One-bit products, XNOR means same sign
   assign cos_hit = ar ~^ br;
   assign sin_hit = ar ~^ bi;

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         valid <= 1'b0;
      end else begin
         valid <= en;
      end
   end

   // Sums wrap at the accumulator width
   always_ff @(posedge clk_x) begin
      if (en) begin
         qcos <= dcos + {{(corr_pkg::ACCUM_BITS-1){1'b0}}, cos_hit};
         qsin <= dsin + {{(corr_pkg::ACCUM_BITS-1){1'b0}}, sin_hit};
      end
   end

endmodule

// ==== design/accum_ram.sv ====
`timescale 1ns/10ps

module accum_ram #(
   parameter int DEPTH = 16
) (
   input  logic                            clk_x,
   input  logic                            rst_n,
   input  logic                            we,
   input  logic [corr_pkg::INDEX_BITS-1:0] waddr,
   input  logic [corr_pkg::ACCUM_BITS-1:0] wdata,
   input  logic [corr_pkg::INDEX_BITS-1:0] raddr,
   output logic [corr_pkg::ACCUM_BITS-1:0] rdata
);

   logic [corr_pkg::ACCUM_BITS-1:0] mem [DEPTH];

   // Needs a word for every pair
   if (DEPTH < corr_pkg::PAIR_COUNT) begin : g_depth_check
      $error("accum_ram DEPTH below PAIR_COUNT");
   end

   // Cleared by reset so the first pass starts from zero
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, no clock
   assign rdata = mem[raddr];

   a_waddr_range: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      we |-> waddr < DEPTH
   ) else $error("accum_ram write past DEPTH");

endmodule

// ==== design/corr_block.sv ====
`timescale 1ns/10ps

module corr_block (
   input  logic                            clk_x,
   input  logic                            rst_n,
   corr_sample_if.corr                     smp,
   output logic                            vld,
   output logic [corr_pkg::VIS_BITS-1:0]   vis,
   output logic [corr_pkg::INDEX_BITS-1:0] vis_idx
);

   logic [corr_pkg::PAIR_BITS-1:0]    pair_sel;
   logic [corr_pkg::ANT_SEL_BITS-1:0] a_idx;
   logic [corr_pkg::ANT_SEL_BITS-1:0] b_idx;

   // Stage 1 registers
   logic                              go;
   logic                              ar;
   logic                              br;
   logic                              bi;
   logic [corr_pkg::INDEX_BITS-1:0]   idx1;
   logic [corr_pkg::ACCUM_BITS-1:0]   dcos;
   logic [corr_pkg::ACCUM_BITS-1:0]   dsin;

   // Accumulator store and stage 2
   logic [corr_pkg::ACCUM_BITS-1:0]   rd_cos;
   logic [corr_pkg::ACCUM_BITS-1:0]   rd_sin;
   logic [corr_pkg::ACCUM_BITS-1:0]   qcos;
   logic [corr_pkg::ACCUM_BITS-1:0]   qsin;
   logic [corr_pkg::INDEX_BITS-1:0]   idx2;

   // ----------------------------------------
   // Pair lookup
   // ----------------------------------------
   assign pair_sel = corr_pkg::PAIR_TABLE[smp.rd * corr_pkg::PAIR_BITS +: corr_pkg::PAIR_BITS];
   assign {b_idx, a_idx} = pair_sel;

   // ----------------------------------------
   // Stage 1, antenna bits and memory read
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         go <= 1'b0;
      end else begin
         go <= smp.en;
      end
   end

   always_ff @(posedge clk_x) begin
      if (smp.en) begin
         ar   <= smp.re[a_idx];
         br   <= smp.re[b_idx];
         bi   <= smp.im[b_idx];
         idx1 <= smp.rd;
         // Zero input restarts the sum after a switch
         dcos <= smp.sw ? '0 : rd_cos;
         dsin <= smp.sw ? '0 : rd_sin;
      end
   end

   // ----------------------------------------
   // Stage 2, accumulate
   // ----------------------------------------
   corr_cos_sin u_cos_sin (
      .clk_x (clk_x),
      .rst_n (rst_n),
      .en    (go),
      .ar    (ar),
      .br    (br),
      .bi    (bi),
      .dcos  (dcos),
      .dsin  (dsin),
      .valid (vld),
      .qcos  (qcos),
      .qsin  (qsin)
   );

   // Index follows the data into stage 2
   always_ff @(posedge clk_x) begin
      if (go) begin
         idx2 <= idx1;
      end
   end

   // Write back on the edge that ends the vld cycle
   accum_ram u_ram_cos (
      .clk_x (clk_x),
      .rst_n (rst_n),
      .we    (vld),
      .waddr (idx2),
      .wdata (qcos),
      .raddr (smp.rd),
      .rdata (rd_cos)
   );

   accum_ram u_ram_sin (
      .clk_x (clk_x),
      .rst_n (rst_n),
      .we    (vld),
      .waddr (idx2),
      .wdata (qsin),
      .raddr (smp.rd),
      .rdata (rd_sin)
   );

   assign vis     = {qsin, qcos};
   assign vis_idx = idx2;

   // Index from the sequencer stays inside the table
   a_idx_range: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      vld |-> vis_idx < corr_pkg::PAIR_COUNT
   ) else $error("vis_idx out of range with vld high");

endmodule

// ==== design/corr_unit.sv ====
`timescale 1ns/10ps

module corr_unit (
   input  logic                            clk_x,
   input  logic                            rst_n,
   input  logic                            stb,
   input  logic                            sw_req,
   input  logic [corr_pkg::ANT_COUNT-1:0]  re,
   input  logic [corr_pkg::ANT_COUNT-1:0]  im,
   output logic                            vld,
   output logic [corr_pkg::VIS_BITS-1:0]   vis,
   output logic [corr_pkg::INDEX_BITS-1:0] vis_idx
);

   // Slot stream from sequencer to correlator
   corr_sample_if smp ();

   // ----------------------------------------
   // Sequencer and correlator
   // ----------------------------------------
   corr_sequencer u_seq (
      .clk_x  (clk_x),
      .rst_n  (rst_n),
      .stb    (stb),
      .sw_req (sw_req),
      .re     (re),
      .im     (im),
      .smp    (smp.seq)
   );

   // Results two cycles behind each slot
   corr_block u_block (
      .clk_x   (clk_x),
      .rst_n   (rst_n),
      .smp     (smp.corr),
      .vld     (vld),
      .vis     (vis),
      .vis_idx (vis_idx)
   );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

// Free-running clock and power-on reset
module tb_clock (
   output logic clk_x,
   output logic rst_n
);

   // Half of the 40 ns period
   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 5;

   initial begin
      clk_x = 1'b0;
      forever begin
         #(HALF_PERIOD) clk_x = ~clk_x;
      end
   end

   // Reset over five rising edges, released mid-cycle
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_x);
      @(negedge clk_x);
      rst_n = 1'b1;
   end

endmodule

// ==== test/tb_corr_checker.sv ====
`timescale 1ns/10ps

module tb_corr_checker (
   input logic                            clk_x,
   input logic                            stb,
   input logic                            vld,
   input logic [corr_pkg::VIS_BITS-1:0]   vis,
   input logic [corr_pkg::INDEX_BITS-1:0] vis_idx
);

   // Expected words for the pass in flight, set by the testbench top
   logic [corr_pkg::VIS_BITS-1:0] exp_vis [corr_pkg::PAIR_COUNT];
   logic                          chk_vals;

   // Rising edges since the last strobe, parked high before the first
   int since_stb = 1000;
   int pass_cnt  = 0;
   int val_errs  = 0;
   int seq_errs  = 0;

   // ----------------------------------------
   // Strobe tracking
   // ----------------------------------------
   always @(posedge clk_x) begin
      if (stb) begin
         since_stb = 0;
      end else if (since_stb < 1000) begin
         since_stb = since_stb + 1;
      end
   end

   // One result slot, index and value
   task automatic check_slot(input int slot);
      logic [corr_pkg::INDEX_BITS-1:0] exp_idx;
      exp_idx = slot[corr_pkg::INDEX_BITS-1:0];
      if (vis_idx !== exp_idx) begin
         $display("FAILED vis_idx: got 0x%h expected 0x%h", vis_idx, exp_idx);
         val_errs++;
      end
      if (chk_vals && vis !== exp_vis[slot]) begin
         $display("FAILED vis pair %0d: got 0x%h expected 0x%h", slot, vis, exp_vis[slot]);
         val_errs++;
      end
      // Last pair closes the pass
      if (slot == corr_pkg::PAIR_COUNT - 1) begin
         pass_cnt++;
      end
   endtask

   // ----------------------------------------
   // Output checks mid-cycle
   // ----------------------------------------
   // Pair k leaves two edges after its slot, i.e. edge T+2+k
   always @(negedge clk_x) begin
      int   slot;
      logic in_pass;
      slot    = since_stb - 2;
      in_pass = (slot >= 0) && (slot < corr_pkg::PAIR_COUNT);
      if (vld && !in_pass) begin
         $display("Extra vld cycle outside a pass with vis_idx %0d", vis_idx);
         seq_errs++;
      end else if (!vld && in_pass) begin
         $display("Missing vld cycle for pair %0d", slot);
         seq_errs++;
      end else if (vld) begin
         check_slot(slot);
      end
   end

endmodule

// ==== test/tb_corr_unit.sv ====
`timescale 1ns/10ps

module tb_corr_unit;

   // Stim line is clear flag, repeat count, re, im, then one word per pair
   localparam int LINE_WORDS  = 4 + corr_pkg::PAIR_COUNT;
   localparam int STIM_LINES  = 9;
   localparam int SAMPLE_GAP  = 16;
   localparam int TIMEOUT_PAD = 50;

   logic                            clk_x;
   logic                            rst_n;
   logic                            stb;
   logic                            sw_req;
   logic [corr_pkg::ANT_COUNT-1:0]  re;
   logic [corr_pkg::ANT_COUNT-1:0]  im;
   logic                            vld;
   logic [corr_pkg::VIS_BITS-1:0]   vis;
   logic [corr_pkg::INDEX_BITS-1:0] vis_idx;

   logic [corr_pkg::VIS_BITS-1:0] stim_mem [STIM_LINES*LINE_WORDS];

   int total_passes = 0;
   int cycle_limit  = 0;
   int cycles       = 0;
   int timeouts     = 0;
   int setup_errs   = 0;

   tb_clock u_clk (.clk_x(clk_x), .rst_n(rst_n));

   corr_unit DUT (
      .clk_x   (clk_x),
      .rst_n   (rst_n),
      .stb     (stb),
      .sw_req  (sw_req),
      .re      (re),
      .im      (im),
      .vld     (vld),
      .vis     (vis),
      .vis_idx (vis_idx)
   );

   tb_corr_checker u_chk (
      .clk_x   (clk_x),
      .stb     (stb),
      .vld     (vld),
      .vis     (vis),
      .vis_idx (vis_idx)
   );

   // One strobe, expected words only valid after the last repeat
   task automatic drive_sample(input int line, input bit first, input bit last);
      int base;
      base = line * LINE_WORDS;
      @(negedge clk_x);
      for (int k = 0; k < corr_pkg::PAIR_COUNT; k++) begin
         u_chk.exp_vis[k] = stim_mem[base + 4 + k];
      end
      u_chk.chk_vals = last;
      sw_req = first & stim_mem[base][0];
      stb    = 1'b1;
      re     = stim_mem[base + 2];
      im     = stim_mem[base + 3];
      @(negedge clk_x);
      stb    = 1'b0;
      sw_req = 1'b0;
      repeat (SAMPLE_GAP - 2) @(negedge clk_x);
   endtask

   task automatic finish_run();
      int fails;
      fails = u_chk.val_errs + u_chk.seq_errs + timeouts + setup_errs;
      $display("Errors: %0d value, %0d sequence, %0d timeout, %0d setup",
               u_chk.val_errs, u_chk.seq_errs, timeouts, setup_errs);
      if (fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------
   always @(posedge clk_x) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Run timed out after %0d cycles with %0d of %0d passes seen",
                  cycles, u_chk.pass_cnt, total_passes);
         timeouts = timeouts + 1;
         finish_run();
      end
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      int reps;
      stb            = 1'b0;
      sw_req         = 1'b0;
      re             = '0;
      im             = '0;
      u_chk.chk_vals = 1'b0;
      $readmemh("test/corr_stim.txt", stim_mem);
      for (int n = 0; n < STIM_LINES; n++) begin
         total_passes += int'(stim_mem[n * LINE_WORDS + 1]);
      end
      cycle_limit = total_passes * SAMPLE_GAP + TIMEOUT_PAD;
      if (total_passes == 0) begin
         $display("No samples were read from test/corr_stim.txt");
         setup_errs++;
      end else begin
         @(posedge rst_n);
         // Quiet stretch after reset, vld must stay low
         repeat (4) @(negedge clk_x);
         for (int n = 0; n < STIM_LINES; n++) begin
            reps = int'(stim_mem[n * LINE_WORDS + 1]);
            for (int r = 0; r < reps; r++) begin
               drive_sample(n, r == 0, r == reps - 1);
            end
         end
         // Last pass drains through the pipeline
         while (u_chk.pass_cnt < total_passes) begin
            @(posedge clk_x);
         end
         repeat (2) @(negedge clk_x);
      end
      finish_run();
   end

endmodule

// ==== test/corr_stim.txt ====
// Columns clr reps re im then expected vis for pairs 0 to 11 (sine high, cosine low)
// Expected words hold after the last of the repeated samples on that line
// First sample after reset then plain accumulation
0 0001 505050 282828 001001 000001 001000 000000 001001 000001 001000 000000 001001 000001 001000 000000
0 0001 000000 000000 002002 001002 002001 001001 002002 001002 002001 001001 002002 001002 002001 001001
0 0003 505050 282828 005005 001005 005001 001001 005005 001005 005001 001001 005005 001005 005001 001001
// Clear with the complement pattern then accumulate again
1 0001 afafaf d7d7d7 001001 000001 001000 000000 001001 000001 001000 000000 001001 000001 001000 000000
0 0001 000000 000000 002002 001002 002001 001001 002002 001002 002001 001001 002002 001002 002001 001001
// Only pair 5 differs from the all-zero sample
0 0001 000400 000000 003003 002003 003002 002002 003003 001002 003002 002002 003003 002003 003002 002002
0 0001 000000 000000 004004 003004 004003 003003 004004 002003 004003 003003 004004 003004 004003 003003
// Clear then 4098 identical samples wrap past 4096
1 1002 505050 282828 002002 000002 002000 000000 002002 000002 002000 000000 002002 000002 002000 000000
0 0001 000000 000000 003003 001003 003001 001001 003003 001003 003001 001001 003003 001003 003001 001001

// ==== visibility_correlator.f ====
design/corr_pkg.sv
design/corr_sample_if.sv
design/corr_sequencer.sv
design/corr_cos_sin.sv
design/accum_ram.sv
design/corr_block.sv
design/corr_unit.sv
test/tb_clock.sv
test/tb_corr_checker.sv
test/tb_corr_unit.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_corr_unit

all: run

$(SIM): visibility_correlator.f design/*.sv test/*.sv
	verilator --binary --assert --top-module tb_corr_unit -f visibility_correlator.f

run: $(SIM) test/corr_stim.txt
	./$(SIM) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
